/* lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    // LC-3b encodings of the supported subset
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // ADD, AND, NOT
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dest;
        lc3b_reg    src1;
        logic       imm_flag;
        logic [4:0] imm5_src2;    // imm5, or src2 in [2:0]
    } lc3b_op_fmt_t;

    // LDR, STR
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    data_reg;     // dest for LDR, source for STR
        lc3b_reg    base;
        logic [5:0] offset6;
    } lc3b_mem_fmt_t;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_nzp    nzp;
        logic [8:0] offset9;
    } lc3b_br_fmt_t;

    typedef union packed {
        lc3b_op_fmt_t  operate;
        lc3b_mem_fmt_t memory;
        lc3b_br_fmt_t  branch;
    } lc3b_instr_t;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       imm_flag;     // alu b from imm
        logic       load_regfile;
        logic       load_cc;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic       is_nop;
    } lc3b_ctrl_t;

    typedef struct packed {
        logic     read;
        logic     write;
        lc3b_word addr;
        lc3b_word wdata;
    } lc3b_mem_req_t;

    localparam lc3b_word RESET_PC = 16'h0000;
    localparam lc3b_word NOP_WORD = 16'h0000;    // BR with nzp = 000

endpackage

`default_nettype wire

/* lc3b_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_decoder
(
    input  wire lc3b_pkg::lc3b_instr_t instr,
    output lc3b_pkg::lc3b_ctrl_t       ctrl,
    output lc3b_pkg::lc3b_reg          sr1,
    output lc3b_pkg::lc3b_reg          sr2,
    output lc3b_pkg::lc3b_reg          dest,
    output lc3b_pkg::lc3b_word         imm
);
    import lc3b_pkg::*;

    always_comb
    begin
        ctrl        = '0;
        ctrl.opcode = instr.operate.opcode;
        ctrl.aluop  = alu_pass;
        sr1         = 3'b000;
        sr2         = 3'b000;
        dest        = 3'b000;
        imm         = 16'h0000;

        if (instr == NOP_WORD)
        begin
            ctrl.is_nop = 1'b1;
        end
        else
        begin
            case (instr.operate.opcode)
                op_add, op_and:
                begin
                    ctrl.aluop        = (instr.operate.opcode == op_add) ? alu_add : alu_and;
                    ctrl.imm_flag     = instr.operate.imm_flag;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc      = 1'b1;
                    sr1  = instr.operate.src1;
                    sr2  = instr.operate.imm5_src2[2:0];
                    dest = instr.operate.dest;
                    imm  = {{11{instr.operate.imm5_src2[4]}}, instr.operate.imm5_src2};
                end
                op_not:
                begin
                    ctrl.aluop        = alu_not;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc      = 1'b1;
                    sr1  = instr.operate.src1;
                    dest = instr.operate.dest;
                end
                op_ldr, op_str:
                begin
                    ctrl.aluop    = alu_add;    // base + offset
                    ctrl.imm_flag = 1'b1;
                    sr1 = instr.memory.base;
                    imm = {{9{instr.memory.offset6[5]}}, instr.memory.offset6, 1'b0};
                    if (instr.memory.opcode == op_ldr)
                    begin
                        ctrl.mem_read     = 1'b1;
                        ctrl.load_regfile = 1'b1;
                        ctrl.load_cc      = 1'b1;
                        dest = instr.memory.data_reg;
                    end
                    else
                    begin
                        ctrl.mem_write = 1'b1;
                        sr2 = instr.memory.data_reg;    // store data on b port
                    end
                end
                op_br:
                begin
                    ctrl.aluop     = alu_add;    // npc + offset
                    ctrl.imm_flag  = 1'b1;
                    ctrl.is_branch = 1'b1;
                    dest = instr.branch.nzp;    // nzp rides in the dest field
                    imm  = {{6{instr.branch.offset9[8]}}, instr.branch.offset9, 1'b0};
                end
                default:
                    ctrl.is_nop = 1'b1;    // unsupported opcode
            endcase
        end
    end

endmodule

`default_nettype wire

/* lc3b_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_regfile
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     load,
    input  wire lc3b_pkg::lc3b_reg  dest,
    input  wire lc3b_pkg::lc3b_word in,
    input  wire lc3b_pkg::lc3b_reg  src_a,
    input  wire lc3b_pkg::lc3b_reg  src_b,
    output lc3b_pkg::lc3b_word      reg_a,
    output lc3b_pkg::lc3b_word      reg_b
);
    import lc3b_pkg::*;

    lc3b_word regs [8];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            regs <= '{default: '0};
        else if (load)
            regs[dest] <= in;
    end

    // read is combinational
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule

`default_nettype wire

/* lc3b_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_datapath
(
    input  wire                     clk,
    input  wire                     arst_n,
    output lc3b_pkg::lc3b_mem_req_t fetch_req,
    input  wire                     fetch_resp,
    output lc3b_pkg::lc3b_mem_req_t data_req,
    input  wire                     data_resp,
    input  wire lc3b_pkg::lc3b_word rdata
);
    import lc3b_pkg::*;

    typedef struct packed {
        lc3b_reg  sr1;
        lc3b_reg  sr2;
        lc3b_reg  dest;    // nzp for BR
        lc3b_word imm;
        lc3b_word npc;
    } ex_data_t;

    typedef struct packed {
        lc3b_word result;    // alu result, load/store address or branch target
        lc3b_word wdata;
        lc3b_reg  dest;
    } mw_data_t;

    lc3b_word    pc;
    logic        fetch_started;
    logic        fbuf_valid;
    lc3b_word    fbuf;
    logic        data_done;
    lc3b_word    dbuf;
    lc3b_instr_t fetch_instr;
    lc3b_ctrl_t  dec_ctrl;
    lc3b_reg     dec_sr1;
    lc3b_reg     dec_sr2;
    lc3b_reg     dec_dest;
    lc3b_word    dec_imm;
    lc3b_ctrl_t  ex_ctrl;
    ex_data_t    ex_data;
    ex_data_t    ex_data_d;
    lc3b_ctrl_t  mw_ctrl;
    lc3b_ctrl_t  mw_ctrl_d;
    mw_data_t    mw_data;
    mw_data_t    mw_data_d;
    lc3b_nzp     cc;
    lc3b_nzp     cc_d;
    lc3b_word    reg_a;
    lc3b_word    reg_b;
    lc3b_word    fwd_a;
    lc3b_word    fwd_b;
    lc3b_word    alu_a;
    lc3b_word    alu_b;
    lc3b_word    alu_out;
    lc3b_word    load_data;
    lc3b_word    wb_value;
    logic        mw_mem;
    logic        global_load;
    logic        br_taken;

    always_comb
    begin
        mw_mem      = mw_ctrl.mem_read | mw_ctrl.mem_write;
        global_load = (fetch_resp | fbuf_valid) & (data_resp | data_done | ~mw_mem);
        load_data   = data_done ? dbuf : rdata;
        wb_value    = mw_ctrl.mem_read ? load_data : mw_data.result;
        br_taken    = mw_ctrl.is_branch & ~mw_ctrl.is_nop & |(mw_data.dest & cc);
        fetch_instr = br_taken ? NOP_WORD : (fbuf_valid ? fbuf : rdata);    // squash on flush

        ex_data_d = '{sr1: dec_sr1, sr2: dec_sr2, dest: dec_dest, imm: dec_imm,
                      npc: pc + 16'd2};

        // writeback result forwarded into execute
        fwd_a = (mw_ctrl.load_regfile && mw_data.dest == ex_data.sr1) ? wb_value : reg_a;
        fwd_b = (mw_ctrl.load_regfile && mw_data.dest == ex_data.sr2) ? wb_value : reg_b;
        alu_a = (ex_ctrl.opcode == op_br) ? ex_data.npc : fwd_a;
        alu_b = ex_ctrl.imm_flag ? ex_data.imm : fwd_b;

        case (ex_ctrl.aluop)
            alu_add: alu_out = alu_a + alu_b;
            alu_and: alu_out = alu_a & alu_b;
            alu_not: alu_out = ~alu_a;
            default: alu_out = alu_b;
        endcase

        mw_ctrl_d = ex_ctrl;
        if (br_taken)
        begin
            mw_ctrl_d        = '0;    // bubble replaces the execute instruction
            mw_ctrl_d.is_nop = 1'b1;
        end
        mw_data_d = '{result: alu_out, wdata: fwd_b, dest: ex_data.dest};

        if (wb_value[15])
            cc_d = 3'b100;
        else if (wb_value == 16'h0000)
            cc_d = 3'b010;
        else
            cc_d = 3'b001;

        fetch_req = '{read: fetch_started & ~fbuf_valid, write: 1'b0, addr: pc,
                      wdata: 16'h0000};
        data_req  = '{read: mw_ctrl.mem_read & ~data_done, write: mw_ctrl.mem_write & ~data_done,
                      addr: mw_data.result, wdata: mw_data.wdata};
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc            <= RESET_PC;
            fetch_started <= 1'b0;    // bus quiet in the first cycle
            fbuf_valid    <= 1'b0;
            data_done     <= 1'b0;
            ex_ctrl       <= '0;
            mw_ctrl       <= '0;
            cc            <= 3'b010;
        end
        else
        begin
            fetch_started <= 1'b1;
            if (global_load)
            begin
                pc         <= br_taken ? mw_data.result : pc + 16'd2;
                fbuf_valid <= 1'b0;
                data_done  <= 1'b0;
                ex_ctrl    <= dec_ctrl;
                mw_ctrl    <= mw_ctrl_d;
                if (mw_ctrl.load_cc)
                    cc <= cc_d;
            end
            else
            begin
                if (fetch_resp)
                    fbuf_valid <= 1'b1;
                if (data_resp)
                    data_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (global_load)
        begin
            ex_data <= ex_data_d;
            mw_data <= mw_data_d;
        end
        if (fetch_resp && !global_load)
            fbuf <= rdata;    // early fetch word
        if (data_resp && !global_load)
            dbuf <= rdata;    // early load word
    end

    lc3b_decoder decoder_i
    (
        .instr (fetch_instr),
        .ctrl  (dec_ctrl),
        .sr1   (dec_sr1),
        .sr2   (dec_sr2),
        .dest  (dec_dest),
        .imm   (dec_imm)
    );

    lc3b_regfile regfile_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (global_load & mw_ctrl.load_regfile),
        .dest   (mw_data.dest),
        .in     (wb_value),
        .src_a  (ex_data.sr1),
        .src_b  (ex_data.sr2),
        .reg_a  (reg_a),
        .reg_b  (reg_b)
    );

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter
(
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire lc3b_pkg::lc3b_mem_req_t fetch_req,
    input  wire lc3b_pkg::lc3b_mem_req_t data_req,
    output logic                         fetch_resp,
    output logic                         data_resp,
    output lc3b_pkg::lc3b_mem_req_t      mem_req,
    input  wire                          mem_resp
);
    import lc3b_pkg::*;

    logic busy;
    logic owner;    // 1 = data port
    logic fetch_pend;
    logic data_pend;
    logic sel_data;

    always_comb
    begin
        fetch_pend = fetch_req.read | fetch_req.write;
        data_pend  = data_req.read | data_req.write;
        sel_data   = busy ? owner : data_pend;    // data wins when idle

        mem_req    = sel_data ? data_req : fetch_req;
        fetch_resp = mem_resp & ~sel_data;
        data_resp  = mem_resp & sel_data;
    end

    // grant held until the access completes
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy  <= 1'b0;
            owner <= 1'b0;
        end
        else if (mem_resp)
        begin
            busy <= 1'b0;
        end
        else if (!busy && (fetch_pend || data_pend))
        begin
            busy  <= 1'b1;
            owner <= data_pend;
        end
    end

endmodule

`default_nettype wire

/* lc3b_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_cpu
(
    input  wire                     clk,
    input  wire                     arst_n,
    output lc3b_pkg::lc3b_mem_req_t mem_req,
    input  wire lc3b_pkg::lc3b_word mem_rdata,
    input  wire                     mem_resp
);
    import lc3b_pkg::*;

    lc3b_mem_req_t fetch_req;
    lc3b_mem_req_t data_req;
    logic          fetch_resp;
    logic          data_resp;

    lc3b_datapath datapath_i
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .data_req   (data_req),
        .data_resp  (data_resp),
        .rdata      (mem_rdata)    // shared by both ports
    );

    mem_arbiter arbiter_i
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .data_req   (data_req),
        .fetch_resp (fetch_resp),
        .data_resp  (data_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

endmodule

`default_nettype wire

/* lc3b_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_checker
(
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire lc3b_pkg::lc3b_mem_req_t mem_req,
    input  wire                          mem_resp,
    output logic                         done,
    output int                           error_count,
    output int                           seen_count,
    output int                           expected_count
);
    import lc3b_pkg::*;

    lc3b_word exp_addr [$];
    lc3b_word exp_data [$];
    int       cycles_out_of_reset;

    assign done = (expected_count > 0) && (seen_count == expected_count);

    // queued in program order
    task automatic expect_store(input lc3b_word addr, input lc3b_word data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        expected_count = expected_count + 1;
    endtask

    task automatic report_missing();
        int missing;
        missing = expected_count - seen_count;
        if (missing > 0)
        begin
            $display("%0d expected stores never appeared on the memory bus", missing);
            error_count = error_count + missing;
        end
    endtask

    always @(posedge clk)
    begin
        if (arst_n)
        begin
            cycles_out_of_reset = cycles_out_of_reset + 1;
            if (cycles_out_of_reset == 1 && (mem_req.read || mem_req.write))
            begin
                $display("bus request seen in the first cycle after reset at %0t", $time);
                error_count = error_count + 1;
            end

            if (mem_resp && mem_req.write)    // one completed write
            begin
                if (exp_addr.size() == 0)
                begin
                    $display("unexpected extra store to address %h at %0t", mem_req.addr, $time);
                    error_count = error_count + 1;
                end
                else
                begin
                    if (mem_req.addr !== exp_addr[0])
                    begin
                        $display("[FAIL] %0t mem_req.addr expected %h got %h",
                                 $time, exp_addr[0], mem_req.addr);
                        error_count = error_count + 1;
                    end
                    if (mem_req.wdata !== exp_data[0])
                    begin
                        $display("[FAIL] %0t mem_req.wdata expected %h got %h",
                                 $time, exp_data[0], mem_req.wdata);
                        error_count = error_count + 1;
                    end
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                    seen_count = seen_count + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_lc3b_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lc3b_cpu;
    import lc3b_pkg::*;

    typedef struct packed {
        lc3b_word instr;
        logic     is_store;
        lc3b_word addr;
        lc3b_word data;
    } row_t;

    localparam int NUM_ROWS  = 31;
    localparam int TIMEOUT   = NUM_ROWS * 20 + 100;
    localparam int DATA_WORD = 'h80;    // byte address 0x100

    // instruction, store flag, expected store address and data
    row_t prog [NUM_ROWS] = '{
        '{16'h1DA8, 1'b0, 16'h0000, 16'h0000},    // ADD R6,R6,#8
        '{16'h1D86, 1'b0, 16'h0000, 16'h0000},    // ADD R6,R6,R6 -> 16
        '{16'h1D86, 1'b0, 16'h0000, 16'h0000},
        '{16'h1D86, 1'b0, 16'h0000, 16'h0000},
        '{16'h1D86, 1'b0, 16'h0000, 16'h0000},
        '{16'h1D86, 1'b0, 16'h0000, 16'h0000},    // R6 = 0x0100
        '{16'h1225, 1'b0, 16'h0000, 16'h0000},    // ADD R1,R0,#5
        '{16'h143D, 1'b0, 16'h0000, 16'h0000},    // ADD R2,R0,#-3
        '{16'h1642, 1'b0, 16'h0000, 16'h0000},    // ADD R3,R1,R2 = 2
        '{16'h7788, 1'b1, 16'h0110, 16'h0002},    // STR R3,R6,#8
        '{16'h58AC, 1'b0, 16'h0000, 16'h0000},    // AND R4,R2,#12
        '{16'h7989, 1'b1, 16'h0112, 16'h000C},    // STR R4,R6,#9
        '{16'h5A81, 1'b0, 16'h0000, 16'h0000},    // AND R5,R2,R1 = 5
        '{16'h9B7F, 1'b0, 16'h0000, 16'h0000},    // NOT R5,R5
        '{16'h7B8A, 1'b1, 16'h0114, 16'hFFFA},    // STR R5,R6,#10
        '{16'h6380, 1'b0, 16'h0000, 16'h0000},    // LDR R1,R6,#0
        '{16'h1261, 1'b0, 16'h0000, 16'h0000},    // ADD R1,R1,#1 right after load
        '{16'h738B, 1'b1, 16'h0116, 16'h1235},    // STR R1,R6,#11
        '{16'h6581, 1'b0, 16'h0000, 16'h0000},    // LDR R2,R6,#1 from 0x102
        '{16'h758C, 1'b1, 16'h0118, 16'hF00F},    // STR R2,R6,#12
        '{16'h0802, 1'b0, 16'h0000, 16'h0000},    // BRn +2, taken
        '{16'h738D, 1'b0, 16'h0000, 16'h0000},    // skipped
        '{16'h758D, 1'b0, 16'h0000, 16'h0000},    // skipped
        '{16'h0401, 1'b0, 16'h0000, 16'h0000},    // BRz +1, not taken
        '{16'h778E, 1'b1, 16'h011C, 16'h0002},    // STR R3,R6,#14
        '{16'h798F, 1'b1, 16'h011E, 16'h000C},    // STR R4,R6,#15
        '{16'h1E20, 1'b0, 16'h0000, 16'h0000},    // ADD R7,R0,#0 sets z
        '{16'h0401, 1'b0, 16'h0000, 16'h0000},    // BRz +1, taken
        '{16'h738D, 1'b0, 16'h0000, 16'h0000},    // skipped
        '{16'h7F90, 1'b1, 16'h0120, 16'h0000},    // STR R7,R6,#16
        '{16'h0FFF, 1'b0, 16'h0000, 16'h0000}     // BR to itself
    };

    logic          clk;
    logic          arst_n;
    lc3b_mem_req_t mem_req;
    lc3b_word      mem_rdata;
    logic          mem_resp;
    lc3b_word      mem [512];
    integer        seed;
    int            wait_cnt;
    logic          mem_busy;
    int            cycle_cnt;
    int            timeout_errors;
    int            total_errors;
    logic          chk_done;
    int            chk_errors;
    int            chk_seen;
    int            chk_expected;

    lc3b_cpu lc3b_cpu_i
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

    lc3b_checker checker_i
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_req        (mem_req),
        .mem_resp       (mem_resp),
        .done           (chk_done),
        .error_count    (chk_errors),
        .seen_count     (chk_seen),
        .expected_count (chk_expected)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory with 1 to 4 cycles of latency per access
    always @(posedge clk)
    begin
        #2;
        if (!arst_n)
        begin
            mem_resp = 1'b0;
            mem_busy = 1'b0;
        end
        else if (mem_resp)
        begin
            mem_resp = 1'b0;
            mem_busy = 1'b0;
        end
        else if (mem_busy)
        begin
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0)
            begin
                mem_rdata = mem[mem_req.addr[9:1]];
                if (mem_req.write)
                    mem[mem_req.addr[9:1]] = mem_req.wdata;
                mem_resp = 1'b1;
            end
        end
        else if (mem_req.read || mem_req.write)
        begin
            mem_busy = 1'b1;
            wait_cnt = 1 + ($random(seed) & 3);
        end
    end

    initial
    begin
        arst_n         = 1'b0;
        mem_resp       = 1'b0;
        mem_rdata      = 16'h0000;
        mem_busy       = 1'b0;
        wait_cnt       = 0;
        seed           = 97183;
        timeout_errors = 0;
        cycle_cnt      = 0;

        for (int i = 0; i < 512; i++)
            mem[i] = lc3b_word'((i * 40503) ^ 16'hC35A);
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            mem[i] = prog[i].instr;
            if (prog[i].is_store)
                checker_i.expect_store(prog[i].addr, prog[i].data);
        end
        mem[DATA_WORD]     = 16'h1234;
        mem[DATA_WORD + 1] = 16'hF00F;

        repeat (3) @(posedge clk);
        #2 arst_n = 1'b1;

        while (!chk_done && cycle_cnt < TIMEOUT)
        begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        if (!chk_done)
        begin
            $display("timeout after %0d cycles waiting for the expected stores", cycle_cnt);
            checker_i.report_missing();
            timeout_errors = 1;
        end

        repeat (20) @(posedge clk);    // catch stray stores
        total_errors = chk_errors + timeout_errors;
        $display("errors: %0d (checker %0d, timeout %0d), stores seen %0d of %0d",
                 total_errors, chk_errors, timeout_errors, chk_seen, chk_expected);
        if (total_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
lc3b_pkg.sv
lc3b_decoder.sv
lc3b_regfile.sv
lc3b_datapath.sv
mem_arbiter.sv
lc3b_cpu.sv
lc3b_checker.sv
tb_lc3b_cpu.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_lc3b_cpu
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
